// ==== rtl/mcast_xbar_pkg.sv ====
// Multicast crossbar definitions
`default_nettype none

package mcast_xbar_pkg;

  // Port counts
  localparam int NUM_SLV = 2;
  localparam int NUM_MST = 4;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = DATA_W / 8;

  // Derived index and counter widths
  localparam int SLV_IDX_W = $clog2(NUM_SLV);
  localparam int CNT_W     = $clog2(NUM_MST + 1);

  // Address bits that pick one 4 KiB master region
  localparam int REGION_LSB = 12;
  localparam int REGION_MSB = 13;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [STRB_W-1:0]  strb_t;
  typedef logic [1:0]         resp_t;
  typedef logic [NUM_SLV-1:0] slv_set_t;
  typedef logic [NUM_MST-1:0] mst_set_t;

  // Slice payloads; W carries data above strobe
  typedef logic [ADDR_W-1:0]        aw_payload_t;
  typedef logic [DATA_W+STRB_W-1:0] w_payload_t;

  // Larger code is the worse outcome
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

endpackage

`default_nettype wire

// ==== rtl/mcast_addr_decode.sv ====
// Multicast address decoder
`timescale 1ns/10ps
`default_nettype none

module mcast_addr_decode (
  input  mcast_xbar_pkg::addr_t    addr_i,
  input  mcast_xbar_pkg::addr_t    mask_i,
  output mcast_xbar_pkg::mst_set_t targets_o,
  output logic                     dec_err_o
);

  logic [mcast_xbar_pkg::REGION_MSB-mcast_xbar_pkg::REGION_LSB:0] region_sel;
  logic [mcast_xbar_pkg::REGION_MSB-mcast_xbar_pkg::REGION_LSB:0] region_mask;
  logic                                                           above_map;

  assign region_sel  = addr_i[mcast_xbar_pkg::REGION_MSB:mcast_xbar_pkg::REGION_LSB];
  assign region_mask = mask_i[mcast_xbar_pkg::REGION_MSB:mcast_xbar_pkg::REGION_LSB];

  // Any address bit above the region field falls outside the map
  assign above_map = |addr_i[mcast_xbar_pkg::ADDR_W-1:mcast_xbar_pkg::REGION_MSB+1];

  // A region matches when it differs from the address only in masked bits
  always_comb begin
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      targets_o[m] = !above_map &&
          (((region_sel ^ m[mcast_xbar_pkg::REGION_MSB-mcast_xbar_pkg::REGION_LSB:0])
            & ~region_mask) == '0);
    end
  end

  assign dec_err_o = (targets_o == '0);

endmodule

`default_nettype wire

// ==== rtl/resp_merge_counter.sv ====
// Write response merge counter
`timescale 1ns/10ps
`default_nettype none

module resp_merge_counter (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  logic                                                load_i,
  input  logic [mcast_xbar_pkg::CNT_W-1:0]                    load_count_i,
  input  mcast_xbar_pkg::mst_set_t                            done_i,
  input  mcast_xbar_pkg::resp_t [mcast_xbar_pkg::NUM_MST-1:0] resp_in_i,
  output logic                                                busy_o,
  output mcast_xbar_pkg::resp_t                               resp_o
);

  logic [mcast_xbar_pkg::CNT_W-1:0] cnt_q;
  logic [mcast_xbar_pkg::CNT_W-1:0] done_cnt;
  mcast_xbar_pkg::resp_t            resp_q;
  mcast_xbar_pkg::resp_t            worst;

  // Count this cycle's responses and fold in their codes
  always_comb begin
    done_cnt = '0;
    worst    = resp_q;
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      if (done_i[m]) begin
        done_cnt = done_cnt + 1'b1;
        if (resp_in_i[m] > worst) begin
          worst = resp_in_i[m];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cnt_q  <= '0;
      resp_q <= mcast_xbar_pkg::RESP_OKAY;
    end else if (load_i) begin
      cnt_q  <= load_count_i;
      resp_q <= mcast_xbar_pkg::RESP_OKAY;
    end else begin
      cnt_q  <= cnt_q - done_cnt;
      resp_q <= worst;
    end
  end

  assign busy_o = (cnt_q != '0);
  assign resp_o = resp_q;

  // More responses than outstanding targets means a routing fault upstream
  no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
    !load_i |-> done_cnt <= cnt_q);

endmodule

`default_nettype wire

// ==== rtl/mcast_write_fsm.sv ====
// Slave port write state machine
`timescale 1ns/10ps
`default_nettype none

module mcast_write_fsm (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  logic                                                awvalid_i,
  input  mcast_xbar_pkg::addr_t                               awaddr_i,
  input  mcast_xbar_pkg::addr_t                               awmask_i,
  output logic                                                awready_o,
  input  logic                                                wvalid_i,
  input  mcast_xbar_pkg::data_t                               wdata_i,
  input  mcast_xbar_pkg::strb_t                               wstrb_i,
  output logic                                                wready_o,
  output logic                                                bvalid_o,
  output mcast_xbar_pkg::resp_t                               bresp_o,
  input  logic                                                bready_i,
  output mcast_xbar_pkg::mst_set_t                            req_o,
  output mcast_xbar_pkg::addr_t                               addr_o,
  output mcast_xbar_pkg::data_t                               data_o,
  output mcast_xbar_pkg::strb_t                               strb_o,
  input  mcast_xbar_pkg::mst_set_t                            grant_i,
  input  mcast_xbar_pkg::mst_set_t                            bdone_i,
  input  mcast_xbar_pkg::resp_t [mcast_xbar_pkg::NUM_MST-1:0] bresp_in_i
);

  typedef enum logic [2:0] {
    IDLE,
    ERROR,
    FANOUT,
    WAIT_RESP,
    RESPOND
  } state_e;

  state_e                           state_q;
  logic                             acc_q;
  logic                             accept;
  logic                             dec_err;
  logic                             cnt_busy;
  mcast_xbar_pkg::mst_set_t         targets;
  mcast_xbar_pkg::mst_set_t         req_q;
  mcast_xbar_pkg::mst_set_t         req_left;
  logic [mcast_xbar_pkg::CNT_W-1:0] target_cnt;
  mcast_xbar_pkg::resp_t            merged_resp;
  mcast_xbar_pkg::addr_t            addr_q;
  mcast_xbar_pkg::data_t            data_q;
  mcast_xbar_pkg::strb_t            strb_q;

  mcast_addr_decode i_decode (
    .addr_i    (awaddr_i),
    .mask_i    (awmask_i),
    .targets_o (targets),
    .dec_err_o (dec_err)
  );

  always_comb begin
    target_cnt = '0;
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      if (targets[m]) begin
        target_cnt = target_cnt + 1'b1;
      end
    end
  end

  // Ready pulses one cycle after both AW and W are seen valid
  assign accept   = acc_q && awvalid_i && wvalid_i;
  assign req_left = req_q & ~grant_i;

  resp_merge_counter i_merge (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .load_i       (accept && !dec_err),
    .load_count_i (target_cnt),
    .done_i       (bdone_i),
    .resp_in_i    (bresp_in_i),
    .busy_o       (cnt_busy),
    .resp_o       (merged_resp)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      acc_q   <= 1'b0;
      req_q   <= '0;
    end else begin
      acc_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (accept) begin
            req_q   <= targets;
            state_q <= dec_err ? ERROR : FANOUT;
          end else begin
            acc_q <= awvalid_i && wvalid_i;
          end
        end
        // Each target drops out of the request set once granted
        FANOUT: begin
          req_q <= req_left;
          if (req_left == '0) begin
            state_q <= WAIT_RESP;
          end
        end
        WAIT_RESP: begin
          if (!cnt_busy) begin
            state_q <= RESPOND;
          end
        end
        ERROR, RESPOND: begin
          if (bready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Shared payload for every target copy
  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q <= awaddr_i;
      data_q <= wdata_i;
      strb_q <= wstrb_i;
    end
  end

  assign awready_o = acc_q;
  assign wready_o  = acc_q;
  assign req_o     = req_q;
  assign addr_o    = addr_q;
  assign data_o    = data_q;
  assign strb_o    = strb_q;
  assign bvalid_o  = (state_q == ERROR) || (state_q == RESPOND);
  assign bresp_o   = (state_q == ERROR) ? mcast_xbar_pkg::RESP_DECERR : merged_resp;

  b_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bresp_o));

endmodule

`default_nettype wire

// ==== rtl/lite_reg_slice.sv ====
// One-entry handshake register
`timescale 1ns/10ps
`default_nettype none

module lite_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     in_valid_i,
  input  payload_t in_data_i,
  output logic     in_ready_o,
  output logic     out_valid_o,
  output payload_t out_data_o,
  input  logic     out_ready_i
);

  logic     full_q;
  payload_t data_q;

  // Accepts only while empty
  assign in_ready_o  = !full_q;
  assign out_valid_o = full_q;
  assign out_data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      full_q <= 1'b0;
    end else if (in_valid_i && !full_q) begin
      full_q <= 1'b1;
    end else if (out_ready_i && full_q) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      data_q <= in_data_i;
    end
  end

  out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

`default_nettype wire

// ==== rtl/mst_port_arbiter.sv ====
// Master port round-robin arbiter
`timescale 1ns/10ps
`default_nettype none

module mst_port_arbiter #(
  parameter int MST_IDX = 0
) (
  input  logic                                                clk_i,
  input  logic                                                rst_i,
  input  mcast_xbar_pkg::slv_set_t                            req_i,
  input  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_SLV-1:0] addr_i,
  input  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_SLV-1:0] data_i,
  input  mcast_xbar_pkg::strb_t [mcast_xbar_pkg::NUM_SLV-1:0] strb_i,
  output mcast_xbar_pkg::slv_set_t                            grant_o,
  output mcast_xbar_pkg::slv_set_t                            bdone_o,
  output mcast_xbar_pkg::resp_t                               bresp_o,
  output logic                                                m_awvalid_o,
  output mcast_xbar_pkg::addr_t                               m_awaddr_o,
  input  logic                                                m_awready_i,
  output logic                                                m_wvalid_o,
  output mcast_xbar_pkg::data_t                               m_wdata_o,
  output mcast_xbar_pkg::strb_t                               m_wstrb_o,
  input  logic                                                m_wready_i,
  input  logic                                                m_bvalid_i,
  input  mcast_xbar_pkg::resp_t                               m_bresp_i,
  output logic                                                m_bready_o
);

  logic                                 busy_q;
  mcast_xbar_pkg::slv_set_t             owner_q;
  logic [mcast_xbar_pkg::SLV_IDX_W-1:0] last_q;
  logic [mcast_xbar_pkg::SLV_IDX_W-1:0] pick_idx;
  logic                                 pick_any;
  logic                                 grant_en;
  logic                                 aw_in_ready;
  logic                                 w_in_ready;
  logic                                 b_done;
  mcast_xbar_pkg::aw_payload_t          aw_in;
  mcast_xbar_pkg::aw_payload_t          aw_out;
  mcast_xbar_pkg::w_payload_t           w_in;
  mcast_xbar_pkg::w_payload_t           w_out;

  // Search starts just after the last slave served; nearest requester wins
  always_comb begin
    int unsigned cand;
    pick_idx = last_q;
    pick_any = 1'b0;
    for (int i = mcast_xbar_pkg::NUM_SLV; i >= 1; i--) begin
      cand = (int'(last_q) + i) % mcast_xbar_pkg::NUM_SLV;
      if (req_i[cand]) begin
        pick_idx = cand[mcast_xbar_pkg::SLV_IDX_W-1:0];
        pick_any = 1'b1;
      end
    end
  end

  assign grant_en = !busy_q && aw_in_ready && w_in_ready && pick_any;

  always_comb begin
    grant_o           = '0;
    grant_o[pick_idx] = grant_en;
  end

  // Region field is rewritten to this port's index
  always_comb begin
    aw_in = addr_i[pick_idx];
    aw_in[mcast_xbar_pkg::REGION_MSB:mcast_xbar_pkg::REGION_LSB] =
        MST_IDX[mcast_xbar_pkg::REGION_MSB-mcast_xbar_pkg::REGION_LSB:0];
  end

  assign w_in = {data_i[pick_idx], strb_i[pick_idx]};

  lite_reg_slice #(
    .payload_t (mcast_xbar_pkg::aw_payload_t)
  ) i_aw_slice (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (grant_en),
    .in_data_i   (aw_in),
    .in_ready_o  (aw_in_ready),
    .out_valid_o (m_awvalid_o),
    .out_data_o  (aw_out),
    .out_ready_i (m_awready_i)
  );

  lite_reg_slice #(
    .payload_t (mcast_xbar_pkg::w_payload_t)
  ) i_w_slice (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .in_valid_i  (grant_en),
    .in_data_i   (w_in),
    .in_ready_o  (w_in_ready),
    .out_valid_o (m_wvalid_o),
    .out_data_o  (w_out),
    .out_ready_i (m_wready_i)
  );

  assign m_awaddr_o = aw_out;
  assign m_wdata_o  = w_out[mcast_xbar_pkg::STRB_W +: mcast_xbar_pkg::DATA_W];
  assign m_wstrb_o  = w_out[mcast_xbar_pkg::STRB_W-1:0];

  // One write in flight; owner is held until its B returns
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q  <= 1'b0;
      owner_q <= '0;
      last_q  <= '0;
    end else if (grant_en) begin
      busy_q  <= 1'b1;
      owner_q <= grant_o;
      last_q  <= pick_idx;
    end else if (b_done) begin
      busy_q  <= 1'b0;
    end
  end

  assign m_bready_o = busy_q;
  assign b_done     = busy_q && m_bvalid_i;
  assign bdone_o    = b_done ? owner_q : '0;
  assign bresp_o    = m_bresp_i;

  // Downstream B must follow the hand-off of both AW and W
  b_after_data: assert property (@(posedge clk_i) disable iff (rst_i)
    m_bvalid_i && m_bready_o |-> !m_awvalid_o && !m_wvalid_o);

endmodule

`default_nettype wire

// ==== rtl/mcast_xbar.sv ====
// Multicast write crossbar
`timescale 1ns/10ps
`default_nettype none

module mcast_xbar (
  input  wire                                                 clk_i,
  input  wire                                                 rst_i,
  input  wire  [mcast_xbar_pkg::NUM_SLV-1:0]                  slv_awvalid_i,
  input  wire  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_SLV-1:0] slv_awaddr_i,
  input  wire  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_SLV-1:0] slv_awmask_i,
  output wire  [mcast_xbar_pkg::NUM_SLV-1:0]                  slv_awready_o,
  input  wire  [mcast_xbar_pkg::NUM_SLV-1:0]                  slv_wvalid_i,
  input  wire  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_SLV-1:0] slv_wdata_i,
  input  wire  mcast_xbar_pkg::strb_t [mcast_xbar_pkg::NUM_SLV-1:0] slv_wstrb_i,
  output wire  [mcast_xbar_pkg::NUM_SLV-1:0]                  slv_wready_o,
  output wire  [mcast_xbar_pkg::NUM_SLV-1:0]                  slv_bvalid_o,
  output wire  mcast_xbar_pkg::resp_t [mcast_xbar_pkg::NUM_SLV-1:0] slv_bresp_o,
  input  wire  [mcast_xbar_pkg::NUM_SLV-1:0]                  slv_bready_i,
  output wire  [mcast_xbar_pkg::NUM_MST-1:0]                  mst_awvalid_o,
  output wire  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_MST-1:0] mst_awaddr_o,
  input  wire  [mcast_xbar_pkg::NUM_MST-1:0]                  mst_awready_i,
  output wire  [mcast_xbar_pkg::NUM_MST-1:0]                  mst_wvalid_o,
  output wire  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_MST-1:0] mst_wdata_o,
  output wire  mcast_xbar_pkg::strb_t [mcast_xbar_pkg::NUM_MST-1:0] mst_wstrb_o,
  input  wire  [mcast_xbar_pkg::NUM_MST-1:0]                  mst_wready_i,
  input  wire  [mcast_xbar_pkg::NUM_MST-1:0]                  mst_bvalid_i,
  input  wire  mcast_xbar_pkg::resp_t [mcast_xbar_pkg::NUM_MST-1:0] mst_bresp_i,
  output wire  [mcast_xbar_pkg::NUM_MST-1:0]                  mst_bready_o
);

  // Slave-major and master-major views of the request matrix
  wire mcast_xbar_pkg::mst_set_t [mcast_xbar_pkg::NUM_SLV-1:0] fsm_req;
  wire mcast_xbar_pkg::mst_set_t [mcast_xbar_pkg::NUM_SLV-1:0] fsm_grant;
  wire mcast_xbar_pkg::mst_set_t [mcast_xbar_pkg::NUM_SLV-1:0] fsm_bdone;
  wire mcast_xbar_pkg::slv_set_t [mcast_xbar_pkg::NUM_MST-1:0] arb_req;
  wire mcast_xbar_pkg::slv_set_t [mcast_xbar_pkg::NUM_MST-1:0] arb_grant;
  wire mcast_xbar_pkg::slv_set_t [mcast_xbar_pkg::NUM_MST-1:0] arb_bdone;
  wire mcast_xbar_pkg::resp_t    [mcast_xbar_pkg::NUM_MST-1:0] arb_bresp;
  wire mcast_xbar_pkg::addr_t    [mcast_xbar_pkg::NUM_SLV-1:0] fsm_addr;
  wire mcast_xbar_pkg::data_t    [mcast_xbar_pkg::NUM_SLV-1:0] fsm_data;
  wire mcast_xbar_pkg::strb_t    [mcast_xbar_pkg::NUM_SLV-1:0] fsm_strb;

  for (genvar s = 0; s < mcast_xbar_pkg::NUM_SLV; s++) begin : gen_slv
    mcast_write_fsm i_fsm (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .awvalid_i  (slv_awvalid_i[s]),
      .awaddr_i   (slv_awaddr_i[s]),
      .awmask_i   (slv_awmask_i[s]),
      .awready_o  (slv_awready_o[s]),
      .wvalid_i   (slv_wvalid_i[s]),
      .wdata_i    (slv_wdata_i[s]),
      .wstrb_i    (slv_wstrb_i[s]),
      .wready_o   (slv_wready_o[s]),
      .bvalid_o   (slv_bvalid_o[s]),
      .bresp_o    (slv_bresp_o[s]),
      .bready_i   (slv_bready_i[s]),
      .req_o      (fsm_req[s]),
      .addr_o     (fsm_addr[s]),
      .data_o     (fsm_data[s]),
      .strb_o     (fsm_strb[s]),
      .grant_i    (fsm_grant[s]),
      .bdone_i    (fsm_bdone[s]),
      .bresp_in_i (arb_bresp)
    );
  end

  // Transpose between slave-indexed and master-indexed matrices
  for (genvar s = 0; s < mcast_xbar_pkg::NUM_SLV; s++) begin : gen_cross_slv
    for (genvar m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin : gen_cross_mst
      assign arb_req[m][s]   = fsm_req[s][m];
      assign fsm_grant[s][m] = arb_grant[m][s];
      assign fsm_bdone[s][m] = arb_bdone[m][s];
    end
  end

  for (genvar m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin : gen_mst
    mst_port_arbiter #(
      .MST_IDX (m)
    ) i_arbiter (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (arb_req[m]),
      .addr_i      (fsm_addr),
      .data_i      (fsm_data),
      .strb_i      (fsm_strb),
      .grant_o     (arb_grant[m]),
      .bdone_o     (arb_bdone[m]),
      .bresp_o     (arb_bresp[m]),
      .m_awvalid_o (mst_awvalid_o[m]),
      .m_awaddr_o  (mst_awaddr_o[m]),
      .m_awready_i (mst_awready_i[m]),
      .m_wvalid_o  (mst_wvalid_o[m]),
      .m_wdata_o   (mst_wdata_o[m]),
      .m_wstrb_o   (mst_wstrb_o[m]),
      .m_wready_i  (mst_wready_i[m]),
      .m_bvalid_i  (mst_bvalid_i[m]),
      .m_bresp_i   (mst_bresp_i[m]),
      .m_bready_o  (mst_bready_o[m])
    );
  end

endmodule

`default_nettype wire

// ==== tests/clk_gen.sv ====
// Testbench clock source
`timescale 1ns/10ps
`default_nettype none

module clk_gen (
  output logic clk_o
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
  end

  always #50 clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== tests/mcast_xbar_tb.sv ====
// Multicast crossbar testbench
`timescale 1ns/10ps
`default_nettype none

module mcast_xbar_tb;

  localparam int         NUM_ENTRIES = 16;
  localparam int         CYCLE_LIMIT = NUM_ENTRIES * 80 + 40;
  localparam int         BREADY_HOLD = 3;
  localparam logic [7:0] ERR_BYTE    = 8'hEE;
  localparam int         PH_ADDR     = 0;
  localparam int         PH_RESP     = 1;
  localparam int         PH_DONE     = 2;

  logic                                                 clk;
  logic                                                 rst;
  logic [mcast_xbar_pkg::NUM_SLV-1:0]                   slv_awvalid;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_SLV-1:0]  slv_awaddr;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_SLV-1:0]  slv_awmask;
  logic [mcast_xbar_pkg::NUM_SLV-1:0]                   slv_awready;
  logic [mcast_xbar_pkg::NUM_SLV-1:0]                   slv_wvalid;
  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_SLV-1:0]  slv_wdata;
  mcast_xbar_pkg::strb_t [mcast_xbar_pkg::NUM_SLV-1:0]  slv_wstrb;
  logic [mcast_xbar_pkg::NUM_SLV-1:0]                   slv_wready;
  logic [mcast_xbar_pkg::NUM_SLV-1:0]                   slv_bvalid;
  mcast_xbar_pkg::resp_t [mcast_xbar_pkg::NUM_SLV-1:0]  slv_bresp;
  logic [mcast_xbar_pkg::NUM_SLV-1:0]                   slv_bready;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   mst_awvalid;
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_MST-1:0]  mst_awaddr;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   mst_awready = '0;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   mst_wvalid;
  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_MST-1:0]  mst_wdata;
  mcast_xbar_pkg::strb_t [mcast_xbar_pkg::NUM_MST-1:0]  mst_wstrb;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   mst_wready = '0;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   mst_bvalid = '0;
  mcast_xbar_pkg::resp_t [mcast_xbar_pkg::NUM_MST-1:0]  mst_bresp  = '0;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   mst_bready;

  // Stimulus table; pair launches an entry together with the next one
  int                       tbl_len = 0;
  int                       tbl_port [NUM_ENTRIES];
  logic                     tbl_pair [NUM_ENTRIES];
  logic                     tbl_slow [NUM_ENTRIES];
  mcast_xbar_pkg::addr_t    tbl_addr [NUM_ENTRIES];
  mcast_xbar_pkg::addr_t    tbl_mask [NUM_ENTRIES];
  mcast_xbar_pkg::data_t    tbl_data [NUM_ENTRIES];
  mcast_xbar_pkg::strb_t    tbl_strb [NUM_ENTRIES];
  mcast_xbar_pkg::mst_set_t tbl_tgt  [NUM_ENTRIES];
  mcast_xbar_pkg::resp_t    tbl_resp [NUM_ENTRIES];

  // One responder state slot per master port
  integer                                               seed = 32'h06e2_cec1;
  int                                                   cycle = 0;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   aw_got = '0;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   w_got  = '0;
  logic [mcast_xbar_pkg::NUM_MST-1:0]                   b_hs   = '0;
  int                                                   b_delay [mcast_xbar_pkg::NUM_MST];
  int                                                   aw_cnt  [mcast_xbar_pkg::NUM_MST];
  int                                                   w_cnt   [mcast_xbar_pkg::NUM_MST];
  int                                                   base_aw [mcast_xbar_pkg::NUM_MST];
  int                                                   base_w  [mcast_xbar_pkg::NUM_MST];
  mcast_xbar_pkg::addr_t [mcast_xbar_pkg::NUM_MST-1:0]  last_addr = '0;
  mcast_xbar_pkg::data_t [mcast_xbar_pkg::NUM_MST-1:0]  last_data = '0;
  mcast_xbar_pkg::strb_t [mcast_xbar_pkg::NUM_MST-1:0]  last_strb = '0;

  clk_gen clk_gen_inst (
    .clk_o (clk)
  );

  mcast_xbar mcast_xbar_inst (
    .clk_i         (clk),
    .rst_i         (rst),
    .slv_awvalid_i (slv_awvalid),
    .slv_awaddr_i  (slv_awaddr),
    .slv_awmask_i  (slv_awmask),
    .slv_awready_o (slv_awready),
    .slv_wvalid_i  (slv_wvalid),
    .slv_wdata_i   (slv_wdata),
    .slv_wstrb_i   (slv_wstrb),
    .slv_wready_o  (slv_wready),
    .slv_bvalid_o  (slv_bvalid),
    .slv_bresp_o   (slv_bresp),
    .slv_bready_i  (slv_bready),
    .mst_awvalid_o (mst_awvalid),
    .mst_awaddr_o  (mst_awaddr),
    .mst_awready_i (mst_awready),
    .mst_wvalid_o  (mst_wvalid),
    .mst_wdata_o   (mst_wdata),
    .mst_wstrb_o   (mst_wstrb),
    .mst_wready_i  (mst_wready),
    .mst_bvalid_i  (mst_bvalid),
    .mst_bresp_i   (mst_bresp),
    .mst_bready_o  (mst_bready)
  );

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED at %0t: %s expected %0h, got %0h", $time, name, exp, got);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_entry(input int port, input logic pair, input logic slow,
                           input mcast_xbar_pkg::addr_t addr, input mcast_xbar_pkg::addr_t mask,
                           input mcast_xbar_pkg::data_t data, input mcast_xbar_pkg::strb_t strb,
                           input mcast_xbar_pkg::mst_set_t tgt, input mcast_xbar_pkg::resp_t resp);
    tbl_port[tbl_len] = port;
    tbl_pair[tbl_len] = pair;
    tbl_slow[tbl_len] = slow;
    tbl_addr[tbl_len] = addr;
    tbl_mask[tbl_len] = mask;
    tbl_data[tbl_len] = data;
    tbl_strb[tbl_len] = strb;
    tbl_tgt[tbl_len]  = tgt;
    tbl_resp[tbl_len] = resp;
    tbl_len++;
  endtask

  // Drives one or two slave ports at once until every B has been taken
  task automatic run_group(input int first, input int count);
    int                    ent       [mcast_xbar_pkg::NUM_SLV];
    int                    phase     [mcast_xbar_pkg::NUM_SLV];
    int                    acc_cycle [mcast_xbar_pkg::NUM_SLV];
    int                    stall     [mcast_xbar_pkg::NUM_SLV];
    logic                  held      [mcast_xbar_pkg::NUM_SLV];
    mcast_xbar_pkg::resp_t held_resp [mcast_xbar_pkg::NUM_SLV];
    int                    left;
    int                    s;
    for (int p = 0; p < mcast_xbar_pkg::NUM_SLV; p++) begin
      ent[p]       = 0;
      phase[p]     = PH_DONE;
      acc_cycle[p] = 0;
      stall[p]     = 0;
      held[p]      = 1'b0;
      held_resp[p] = mcast_xbar_pkg::RESP_OKAY;
    end
    for (int k = 0; k < count; k++) begin
      s              = tbl_port[first+k];
      ent[s]         = first + k;
      phase[s]       = PH_ADDR;
      slv_awvalid[s] = 1'b1;
      slv_awaddr[s]  = tbl_addr[first+k];
      slv_awmask[s]  = tbl_mask[first+k];
      slv_wvalid[s]  = 1'b1;
      slv_wdata[s]   = tbl_data[first+k];
      slv_wstrb[s]   = tbl_strb[first+k];
      slv_bready[s]  = !tbl_slow[first+k];
    end
    left = count;
    while (left > 0) begin
      @(posedge clk);
      for (int p = 0; p < mcast_xbar_pkg::NUM_SLV; p++) begin
        if (phase[p] == PH_ADDR && slv_awready[p]) begin
          check_value("slv_wready", 64'(slv_wready[p]), 64'(1));
          acc_cycle[p] = cycle;
          phase[p]     = PH_RESP;
        end else if (phase[p] == PH_RESP && slv_bvalid[p]) begin
          if (held[p]) begin
            check_value("slv_bresp", 64'(slv_bresp[p]), 64'(held_resp[p]));
          end else if (tbl_resp[ent[p]] == mcast_xbar_pkg::RESP_DECERR) begin
            check_value("slv_bvalid latency", 64'(cycle - acc_cycle[p]), 64'(1));
          end
          if (slv_bready[p]) begin
            check_value("slv_bresp", 64'(slv_bresp[p]), 64'(tbl_resp[ent[p]]));
            phase[p] = PH_DONE;
            left--;
          end else begin
            held[p]      = 1'b1;
            held_resp[p] = slv_bresp[p];
          end
        end else if (phase[p] == PH_RESP && held[p]) begin
          check_value("slv_bvalid", 64'(slv_bvalid[p]), 64'(1));
        end else if (phase[p] != PH_RESP) begin
          // A port with no write outstanding must not offer a B
          check_value("slv_bvalid", 64'(slv_bvalid[p]), 64'(0));
        end
      end
      #1;
      for (int p = 0; p < mcast_xbar_pkg::NUM_SLV; p++) begin
        if (phase[p] != PH_ADDR) begin
          slv_awvalid[p] = 1'b0;
          slv_wvalid[p]  = 1'b0;
        end
        if (phase[p] == PH_RESP && held[p]) begin
          stall[p]++;
          if (stall[p] >= BREADY_HOLD) begin
            slv_bready[p] = 1'b1;
          end
        end
        if (phase[p] == PH_DONE) begin
          slv_bready[p] = 1'b0;
        end
      end
    end
  endtask

  // Transfer counts per master, and the payload seen for a lone write
  task automatic check_masters(input int first, input int count);
    int                    exp_cnt;
    mcast_xbar_pkg::addr_t exp_addr;
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      exp_cnt = 0;
      for (int k = 0; k < count; k++) begin
        exp_cnt += int'(tbl_tgt[first+k][m]);
      end
      check_value("mst_awvalid transfers", 64'(aw_cnt[m] - base_aw[m]), 64'(exp_cnt));
      check_value("mst_wvalid transfers", 64'(w_cnt[m] - base_w[m]), 64'(exp_cnt));
      if (count == 1 && tbl_tgt[first][m]) begin
        exp_addr        = tbl_addr[first];
        exp_addr[13:12] = 2'(m);
        check_value("mst_awaddr", 64'(last_addr[m]), 64'(exp_addr));
        check_value("mst_wdata", 64'(last_data[m]), 64'(tbl_data[first]));
        check_value("mst_wstrb", 64'(last_strb[m]), 64'(tbl_strb[first]));
      end
    end
  endtask

  // Master-port responder models with random ready and B delays
  always @(posedge clk) begin
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      // Nothing is held at this port, so no B is awaited
      if (!rst && !aw_got[m] && !mst_awvalid[m]) begin
        check_value("mst_bready", 64'(mst_bready[m]), 64'(0));
      end
      if (mst_awvalid[m] && mst_awready[m]) begin
        check_value("mst_awaddr[13:12]", 64'(mst_awaddr[m][13:12]), 64'(m));
        last_addr[m] = mst_awaddr[m];
        aw_got[m]    = 1'b1;
        aw_cnt[m]++;
      end
      if (mst_wvalid[m] && mst_wready[m]) begin
        last_data[m] = mst_wdata[m];
        last_strb[m] = mst_wstrb[m];
        w_got[m]     = 1'b1;
        w_cnt[m]++;
      end
      if (mst_bvalid[m] && mst_bready[m]) begin
        aw_got[m]  = 1'b0;
        w_got[m]   = 1'b0;
        b_hs[m]    = 1'b1;
        b_delay[m] = $random(seed) & 3;
      end
    end
    #1;
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      mst_awready[m] = !rst && !aw_got[m] && (($random(seed) & 3) != 0);
      mst_wready[m]  = !rst && !w_got[m] && (($random(seed) & 3) != 0);
      if (b_hs[m]) begin
        mst_bvalid[m] = 1'b0;
        b_hs[m]       = 1'b0;
      end else if (aw_got[m] && w_got[m] && !mst_bvalid[m]) begin
        if (b_delay[m] > 0) begin
          b_delay[m]--;
        end else begin
          mst_bvalid[m] = 1'b1;
          mst_bresp[m]  = (last_data[m][31:24] == ERR_BYTE) ?
                          mcast_xbar_pkg::RESP_SLVERR : mcast_xbar_pkg::RESP_OKAY;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("Timeout: the writes did not complete within %0d cycles", CYCLE_LIMIT);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int e;
    int n;
    rst         = 1'b1;
    slv_awvalid = '0;
    slv_awaddr  = '0;
    slv_awmask  = '0;
    slv_wvalid  = '0;
    slv_wdata   = '0;
    slv_wstrb   = '0;
    slv_bready  = '0;
    for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
      b_delay[m] = 1;
      aw_cnt[m]  = 0;
      w_cnt[m]   = 0;
    end
    // port pair slow addr mask data strb targets resp
    add_entry(0, 0, 0, 32'h0000_1010, 32'h0000_0000, 32'h1234_5678, 4'hf, 4'b0010, 2'd0);
    add_entry(1, 0, 0, 32'h0000_3ffc, 32'h0000_0000, 32'ha5a5_0001, 4'h3, 4'b1000, 2'd0);
    add_entry(0, 0, 0, 32'h0000_0040, 32'h0000_1000, 32'h0bad_f00d, 4'hf, 4'b0011, 2'd0);
    add_entry(1, 0, 0, 32'h0000_2004, 32'h0000_2000, 32'h1111_2222, 4'hc, 4'b0101, 2'd0);
    add_entry(0, 0, 0, 32'h0000_1000, 32'h0000_3000, 32'h7e57_0004, 4'hf, 4'b1111, 2'd0);
    add_entry(1, 0, 0, 32'h0000_4000, 32'h0000_0000, 32'hdead_0005, 4'hf, 4'b0000, 2'd3);
    add_entry(0, 0, 0, 32'h8000_0000, 32'hffff_ffff, 32'hdead_0006, 4'h1, 4'b0000, 2'd3);
    add_entry(1, 0, 0, 32'h0000_0100, 32'h0000_3000, 32'hee00_0007, 4'hf, 4'b1111, 2'd2);
    add_entry(0, 0, 0, 32'h0000_2000, 32'h0000_1000, 32'h00ee_ee08, 4'hf, 4'b1100, 2'd0);
    add_entry(0, 1, 0, 32'h0000_1020, 32'h0000_0000, 32'h5555_0009, 4'hf, 4'b0010, 2'd0);
    add_entry(1, 0, 0, 32'h0000_1024, 32'h0000_0000, 32'h6666_000a, 4'h6, 4'b0010, 2'd0);
    add_entry(0, 1, 0, 32'h0000_0000, 32'h0000_3000, 32'h4444_000b, 4'hf, 4'b1111, 2'd0);
    add_entry(1, 0, 0, 32'h0000_3000, 32'h0000_3000, 32'hee44_000c, 4'hf, 4'b1111, 2'd2);
    add_entry(0, 0, 1, 32'h0000_2100, 32'h0000_0000, 32'h3333_000d, 4'hf, 4'b0100, 2'd0);
    add_entry(1, 0, 1, 32'h0001_0000, 32'h0000_0000, 32'h3333_000e, 4'hf, 4'b0000, 2'd3);
    add_entry(0, 0, 1, 32'h0000_1100, 32'h0000_2000, 32'hee00_000f, 4'hf, 4'b1010, 2'd2);
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    e   = 0;
    while (e < tbl_len) begin
      n = tbl_pair[e] ? 2 : 1;
      for (int m = 0; m < mcast_xbar_pkg::NUM_MST; m++) begin
        base_aw[m] = aw_cnt[m];
        base_w[m]  = w_cnt[m];
      end
      run_group(e, n);
      check_masters(e, n);
      e += n;
    end
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/mcast_xbar_pkg.sv
rtl/mcast_addr_decode.sv
rtl/resp_merge_counter.sv
rtl/mcast_write_fsm.sv
rtl/lite_reg_slice.sv
rtl/mst_port_arbiter.sv
rtl/mcast_xbar.sv
tests/clk_gen.sv
tests/mcast_xbar_tb.sv

// ==== Makefile ====
TOP = mcast_xbar_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f \
		-Mdir obj_dir -o $(TOP)_sim

# Pass only when the pass line appears in the simulation output
run: compile
	./obj_dir/$(TOP)_sim | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir
